// File: design/soc_map_pkg.sv
package soc_map_pkg;

    // APB bus widths
    localparam int ApbAddrWidth   = 32;
    localparam int ApbDataWidth   = 32;
    localparam int RegOffsetWidth = 26;

    // --------------------
    // Region map
    // --------------------
    localparam logic [ApbAddrWidth-1:0] ClintBase   = 32'h0200_0000;
    localparam logic [ApbAddrWidth-1:0] ClintLength = 32'h000C_0000;
    localparam logic [ApbAddrWidth-1:0] PlicBase    = 32'h0C00_0000;
    localparam logic [ApbAddrWidth-1:0] PlicLength  = 32'h0400_0000;

    // --------------------
    // CLINT registers
    // --------------------
    localparam logic [RegOffsetWidth-1:0] MsipOffset       = 26'h000_0000;
    localparam logic [RegOffsetWidth-1:0] MtimecmpLoOffset = 26'h000_4000;
    localparam logic [RegOffsetWidth-1:0] MtimecmpHiOffset = 26'h000_4004;
    localparam logic [RegOffsetWidth-1:0] MtimeLoOffset    = 26'h000_BFF8;
    localparam logic [RegOffsetWidth-1:0] MtimeHiOffset    = 26'h000_BFFC;

    // --------------------
    // PLIC registers
    // --------------------
    localparam logic [RegOffsetWidth-1:0] PrioOffset      = 26'h000_0000;
    localparam logic [RegOffsetWidth-1:0] PendingOffset   = 26'h000_1000;
    localparam logic [RegOffsetWidth-1:0] EnableOffset    = 26'h000_2000;
    localparam logic [RegOffsetWidth-1:0] ThresholdOffset = 26'h020_0000;
    localparam logic [RegOffsetWidth-1:0] ClaimOffset     = 26'h020_0004;

endpackage

// File: design/irq_pkg.sv
package irq_pkg;

    // Source 0 is reserved, ids run from 1 to NumSources
    localparam int NumSources  = 31;
    localparam int PrioWidth   = 3;
    localparam int MaxPriority = 7;
    localparam int SrcIdWidth  = 5;

    // Id 0 means no source
    typedef logic [SrcIdWidth-1:0] src_id_t;

endpackage

// File: design/periph_apb_ctrl.sv
`timescale 1ns/1ps

module periph_apb_ctrl (
    input  logic                                   clk_i,
    input  logic                                   ndmreset_n,
    // APB slave
    input  logic                                   psel_i,
    input  logic                                   penable_i,
    input  logic                                   pwrite_i,
    input  logic [soc_map_pkg::ApbAddrWidth-1:0]   paddr_i,
    input  logic [soc_map_pkg::ApbDataWidth-1:0]   pwdata_i,
    output logic [soc_map_pkg::ApbDataWidth-1:0]   prdata_o,
    output logic                                   pready_o,
    output logic                                   pslverr_o,
    // Register blocks
    input  logic [soc_map_pkg::ApbDataWidth-1:0]   clint_rdata_i,
    input  logic [soc_map_pkg::ApbDataWidth-1:0]   plic_rdata_i,
    output logic                                   clint_wr_o,
    output logic                                   clint_rd_o,
    output logic                                   plic_wr_o,
    output logic                                   plic_rd_o,
    output logic [soc_map_pkg::RegOffsetWidth-1:0] reg_offset_o,
    output logic [soc_map_pkg::ApbDataWidth-1:0]   reg_wdata_o
);

    logic                                 setup_q;
    logic                                 access;
    logic                                 clint_hit;
    logic                                 plic_hit;
    logic [soc_map_pkg::ApbAddrWidth-1:0] offset_full;

    // --------------------
    // Transfer phase
    // --------------------
    // Set by a setup cycle, so the next cycle is a proper access
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel_i & ~penable_i;
        end
    end

    assign access = psel_i & penable_i & setup_q;

    // --------------------
    // Region decode
    // --------------------
    assign clint_hit = (paddr_i >= soc_map_pkg::ClintBase) &&
                       (paddr_i < soc_map_pkg::ClintBase + soc_map_pkg::ClintLength);
    assign plic_hit  = (paddr_i >= soc_map_pkg::PlicBase) &&
                       (paddr_i < soc_map_pkg::PlicBase + soc_map_pkg::PlicLength);

    assign offset_full  = paddr_i - (plic_hit ? soc_map_pkg::PlicBase : soc_map_pkg::ClintBase);
    assign reg_offset_o = offset_full[soc_map_pkg::RegOffsetWidth-1:0];
    assign reg_wdata_o  = pwdata_i;

    assign clint_wr_o = access & clint_hit & pwrite_i;
    assign clint_rd_o = access & clint_hit & ~pwrite_i;
    assign plic_wr_o  = access & plic_hit & pwrite_i;
    assign plic_rd_o  = access & plic_hit & ~pwrite_i;

    // --------------------
    // Response
    // --------------------
    // No wait states
    assign pready_o  = psel_i & penable_i;
    assign pslverr_o = access & ~clint_hit & ~plic_hit;

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            if (clint_hit) begin
                prdata_o = clint_rdata_i;
            end else if (plic_hit) begin
                prdata_o = plic_rdata_i;
            end
        end
    end

endmodule

// File: design/clint_timer.sv
`timescale 1ns/1ps

module clint_timer (
    input  logic                                   clk_i,
    input  logic                                   ndmreset_n,
    input  logic                                   wr_i,
    input  logic                                   rd_i,
    input  logic [soc_map_pkg::RegOffsetWidth-1:0] offset_i,
    input  logic [soc_map_pkg::ApbDataWidth-1:0]   wdata_i,
    output logic [soc_map_pkg::ApbDataWidth-1:0]   rdata_o,
    output logic                                   timer_irq_o,
    output logic                                   ipi_o
);

    logic        tick_q;
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        msip_q;

    // Real-time tick at half the clock rate
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            tick_q <= 1'b0;
        end else begin
            tick_q <= ~tick_q;
        end
    end

    // --------------------
    // mtime
    // --------------------
    // Software writes win over the increment
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtime_q <= '0;
        end else if (wr_i && offset_i == soc_map_pkg::MtimeLoOffset) begin
            mtime_q <= {mtime_q[63:32], wdata_i};
        end else if (wr_i && offset_i == soc_map_pkg::MtimeHiOffset) begin
            mtime_q <= {wdata_i, mtime_q[31:0]};
        end else if (tick_q) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // --------------------
    // mtimecmp and msip
    // --------------------
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
        end else if (wr_i) begin
            case (offset_i)
                soc_map_pkg::MtimecmpLoOffset: mtimecmp_q[31:0]  <= wdata_i;
                soc_map_pkg::MtimecmpHiOffset: mtimecmp_q[63:32] <= wdata_i;
                soc_map_pkg::MsipOffset:       msip_q            <= wdata_i[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            case (offset_i)
                soc_map_pkg::MsipOffset:       rdata_o = {31'd0, msip_q};
                soc_map_pkg::MtimecmpLoOffset: rdata_o = mtimecmp_q[31:0];
                soc_map_pkg::MtimecmpHiOffset: rdata_o = mtimecmp_q[63:32];
                soc_map_pkg::MtimeLoOffset:    rdata_o = mtime_q[31:0];
                soc_map_pkg::MtimeHiOffset:    rdata_o = mtime_q[63:32];
                default:                       rdata_o = '0;
            endcase
        end
    end

    assign timer_irq_o = (mtime_q >= mtimecmp_q);
    assign ipi_o       = msip_q;

endmodule

// File: design/plic_core.sv
`timescale 1ns/1ps

module plic_core (
    input  logic                                   clk_i,
    input  logic                                   ndmreset_n,
    input  logic                                   wr_i,
    input  logic                                   rd_i,
    input  logic [soc_map_pkg::RegOffsetWidth-1:0] offset_i,
    input  logic [soc_map_pkg::ApbDataWidth-1:0]   wdata_i,
    input  logic [irq_pkg::NumSources-1:0]         irq_sources_i,
    output logic [soc_map_pkg::ApbDataWidth-1:0]   rdata_o,
    output logic                                   eip_o
);

    // Source k sits at bit k-1 of the source vectors
    logic [irq_pkg::PrioWidth-1:0]  prio_q [1:irq_pkg::NumSources];
    logic [irq_pkg::NumSources-1:0] enable_q;
    logic [irq_pkg::NumSources-1:0] pending_q;
    logic [irq_pkg::NumSources-1:0] pending_d;
    logic [irq_pkg::NumSources-1:0] inflight_q;
    logic [irq_pkg::NumSources-1:0] inflight_d;
    logic [irq_pkg::PrioWidth-1:0]  threshold_q;
    irq_pkg::src_id_t               best_id;
    irq_pkg::src_id_t               complete_id;
    irq_pkg::src_id_t               prio_idx;
    logic                           prio_sel;
    logic                           claim_en;
    logic                           complete_en;

    // --------------------
    // Access decode
    // --------------------
    // Priorities live below 0x80, one word per source
    assign prio_sel = (offset_i[soc_map_pkg::RegOffsetWidth-1:7] ==
                       soc_map_pkg::PrioOffset[soc_map_pkg::RegOffsetWidth-1:7]) &&
                      (offset_i[1:0] == 2'b00);
    assign prio_idx    = offset_i[6:2];
    assign complete_id = wdata_i[irq_pkg::SrcIdWidth-1:0];
    assign claim_en    = rd_i && offset_i == soc_map_pkg::ClaimOffset;
    assign complete_en = wr_i && offset_i == soc_map_pkg::ClaimOffset;

    // --------------------
    // Best source search
    // --------------------
    // Strict compare keeps the lowest id on a tie
    always_comb begin
        logic [irq_pkg::PrioWidth-1:0] best_prio;
        best_prio = threshold_q;
        best_id   = '0;
        for (int i = 1; i <= irq_pkg::NumSources; i++) begin
            if (pending_q[i-1] && enable_q[i-1] && prio_q[i] > best_prio) begin
                best_prio = prio_q[i];
                best_id   = irq_pkg::src_id_t'(i);
            end
        end
    end

    assign eip_o = (best_id != '0);

    // --------------------
    // Gateways
    // --------------------
    always_comb begin
        pending_d  = pending_q | (irq_sources_i & ~inflight_q);
        inflight_d = inflight_q;
        if (complete_en && complete_id != '0) begin
            inflight_d[complete_id-1] = 1'b0;
        end
        // A claimed source stays blocked until its complete
        if (claim_en && best_id != '0) begin
            pending_d[best_id-1]  = 1'b0;
            inflight_d[best_id-1] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            pending_q  <= '0;
            inflight_q <= '0;
        end else begin
            pending_q  <= pending_d;
            inflight_q <= inflight_d;
        end
    end

    // --------------------
    // Config registers
    // --------------------
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            for (int i = 1; i <= irq_pkg::NumSources; i++) begin
                prio_q[i] <= '0;
            end
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (wr_i) begin
            if (prio_sel && prio_idx != '0) begin
                prio_q[prio_idx] <= wdata_i[irq_pkg::PrioWidth-1:0];
            end
            if (offset_i == soc_map_pkg::EnableOffset) begin
                enable_q <= wdata_i[irq_pkg::NumSources:1];
            end
            if (offset_i == soc_map_pkg::ThresholdOffset) begin
                threshold_q <= wdata_i[irq_pkg::PrioWidth-1:0];
            end
        end
    end

    // Read word, bit k of pending and enable is source k
    always_comb begin
        rdata_o = '0;
        if (rd_i) begin
            if (prio_sel && prio_idx != '0) begin
                rdata_o[irq_pkg::PrioWidth-1:0] = prio_q[prio_idx];
            end else if (offset_i == soc_map_pkg::PendingOffset) begin
                rdata_o = {pending_q, 1'b0};
            end else if (offset_i == soc_map_pkg::EnableOffset) begin
                rdata_o = {enable_q, 1'b0};
            end else if (offset_i == soc_map_pkg::ThresholdOffset) begin
                rdata_o[irq_pkg::PrioWidth-1:0] = threshold_q;
            end else if (offset_i == soc_map_pkg::ClaimOffset) begin
                rdata_o[irq_pkg::SrcIdWidth-1:0] = best_id;
            end
        end
    end

endmodule

// File: design/periph_top.sv
`timescale 1ns/1ps

module periph_top (
    input  logic                                 clk_i,
    input  logic                                 ndmreset_n,
    // APB slave
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    input  logic                                 pwrite_i,
    input  logic [soc_map_pkg::ApbAddrWidth-1:0] paddr_i,
    input  logic [soc_map_pkg::ApbDataWidth-1:0] pwdata_i,
    output logic [soc_map_pkg::ApbDataWidth-1:0] prdata_o,
    output logic                                 pready_o,
    output logic                                 pslverr_o,
    // Interrupts
    input  logic [irq_pkg::NumSources-1:0]       irq_sources_i,
    output logic                                 eip_o,
    output logic                                 timer_irq_o,
    output logic                                 ipi_o
);

    logic                                   clint_wr;
    logic                                   clint_rd;
    logic                                   plic_wr;
    logic                                   plic_rd;
    logic [soc_map_pkg::RegOffsetWidth-1:0] reg_offset;
    logic [soc_map_pkg::ApbDataWidth-1:0]   reg_wdata;
    logic [soc_map_pkg::ApbDataWidth-1:0]   clint_rdata;
    logic [soc_map_pkg::ApbDataWidth-1:0]   plic_rdata;

    periph_apb_ctrl ctrl_i (
        .clk_i         ( clk_i         ),
        .ndmreset_n    ( ndmreset_n    ),
        .psel_i        ( psel_i        ),
        .penable_i     ( penable_i     ),
        .pwrite_i      ( pwrite_i      ),
        .paddr_i       ( paddr_i       ),
        .pwdata_i      ( pwdata_i      ),
        .prdata_o      ( prdata_o      ),
        .pready_o      ( pready_o      ),
        .pslverr_o     ( pslverr_o     ),
        .clint_rdata_i ( clint_rdata   ),
        .plic_rdata_i  ( plic_rdata    ),
        .clint_wr_o    ( clint_wr      ),
        .clint_rd_o    ( clint_rd      ),
        .plic_wr_o     ( plic_wr       ),
        .plic_rd_o     ( plic_rd       ),
        .reg_offset_o  ( reg_offset    ),
        .reg_wdata_o   ( reg_wdata     )
    );

    clint_timer clint_i (
        .clk_i       ( clk_i       ),
        .ndmreset_n  ( ndmreset_n  ),
        .wr_i        ( clint_wr    ),
        .rd_i        ( clint_rd    ),
        .offset_i    ( reg_offset  ),
        .wdata_i     ( reg_wdata   ),
        .rdata_o     ( clint_rdata ),
        .timer_irq_o ( timer_irq_o ),
        .ipi_o       ( ipi_o       )
    );

    plic_core plic_i (
        .clk_i         ( clk_i         ),
        .ndmreset_n    ( ndmreset_n    ),
        .wr_i          ( plic_wr       ),
        .rd_i          ( plic_rd       ),
        .offset_i      ( reg_offset    ),
        .wdata_i       ( reg_wdata     ),
        .irq_sources_i ( irq_sources_i ),
        .rdata_o       ( plic_rdata    ),
        .eip_o         ( eip_o         )
    );

endmodule

// File: test/periph_checker.sv
`timescale 1ns/1ps

module periph_checker (
    input logic                                 clk_i,
    input logic                                 ndmreset_n,
    input logic                                 psel_i,
    input logic                                 penable_i,
    input logic [soc_map_pkg::ApbAddrWidth-1:0] paddr_i,
    input logic                                 pready_i,
    input logic                                 pslverr_i
);

    logic clint_mapped;
    logic plic_mapped;

    // Address map as the bus master sees it
    assign clint_mapped = (paddr_i - soc_map_pkg::ClintBase) < soc_map_pkg::ClintLength;
    assign plic_mapped  = (paddr_i - soc_map_pkg::PlicBase) < soc_map_pkg::PlicLength;

    // --------------------
    // APB rules
    // --------------------
    // An access cycle always follows a setup cycle
    ready_in_access: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        pready_i |-> (psel_i && penable_i && $past(psel_i && !penable_i)))
        else $error("pready_o high outside an access cycle");

    err_with_ready: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        pslverr_i |-> (pready_i && !clint_mapped && !plic_mapped))
        else $error("pslverr_o high without pready_o or for a mapped address");

    // Address held from setup into access
    addr_stable: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        (psel_i && !penable_i) |=> $stable(paddr_i))
        else $error("paddr_i changed between setup and access");

endmodule

bind periph_top periph_checker chk_i (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .psel_i     ( psel_i     ),
    .penable_i  ( penable_i  ),
    .paddr_i    ( paddr_i    ),
    .pready_i   ( pready_o   ),
    .pslverr_i  ( pslverr_o  )
);

// File: test/periph_tb.sv
`timescale 1ns/1ps

module periph_tb;

    // Low offset bits from the CLINT base alias msip and mtimecmp
    localparam logic [31:0] UnmappedAddr    = 32'h0600_0000;
    localparam logic [31:0] UnmappedCmpAddr = 32'h0600_4000;

    logic                             clk_i;
    logic                             ndmreset_n;
    logic                             psel_i;
    logic                             penable_i;
    logic                             pwrite_i;
    logic [31:0]                      paddr_i;
    logic [31:0]                      pwdata_i;
    logic [31:0]                      prdata_o;
    logic                             pready_o;
    logic                             pslverr_o;
    logic [irq_pkg::NumSources-1:0]   irq_sources_i;
    logic                             eip_o;
    logic                             timer_irq_o;
    logic                             ipi_o;
    int                               errors;
    int                               tests_run;

    periph_top dut_i (
        .clk_i         ( clk_i         ),
        .ndmreset_n    ( ndmreset_n    ),
        .psel_i        ( psel_i        ),
        .penable_i     ( penable_i     ),
        .pwrite_i      ( pwrite_i      ),
        .paddr_i       ( paddr_i       ),
        .pwdata_i      ( pwdata_i      ),
        .prdata_o      ( prdata_o      ),
        .pready_o      ( pready_o      ),
        .pslverr_o     ( pslverr_o     ),
        .irq_sources_i ( irq_sources_i ),
        .eip_o         ( eip_o         ),
        .timer_irq_o   ( timer_irq_o   ),
        .ipi_o         ( ipi_o         )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    function automatic logic [31:0] clint_addr(input logic [25:0] offset);
        return soc_map_pkg::ClintBase + 32'(offset);
    endfunction

    function automatic logic [31:0] plic_addr(input logic [25:0] offset);
        return soc_map_pkg::PlicBase + 32'(offset);
    endfunction

    function automatic logic [31:0] prio_addr(input int id);
        return plic_addr(soc_map_pkg::PrioOffset) + 32'(id * 4);
    endfunction

    // Setup and access cycle, bus released at the following falling edge
    task automatic apb_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = write;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk_i);
        penable_i = 1'b1;
        #1;
        check("pready_o", 32'd1, pready_o);
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_rdata;
        apb_transfer(1'b1, addr, data, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check("pslverr_o", 32'd0, err);
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        check("pslverr_o", 32'd0, err);
    endtask

    task automatic wait_eip(input int max_cycles);
        int cycles;
        cycles = 0;
        while (!eip_o && cycles < max_cycles) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!eip_o) begin
            $display("timeout: eip_o did not rise within %0d cycles", max_cycles);
            errors++;
        end
    endtask

    task automatic hold_eip_low(input int num_cycles);
        for (int n = 0; n < num_cycles; n++) begin
            @(negedge clk_i);
            check("eip_o", 32'd0, eip_o);
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_state();
        int          errors_before;
        logic [31:0] rdata;
        errors_before = errors;
        check("eip_o", 32'd0, eip_o);
        check("timer_irq_o", 32'd0, timer_irq_o);
        check("ipi_o", 32'd0, ipi_o);
        read_reg(clint_addr(soc_map_pkg::MtimecmpLoOffset), rdata);
        check("mtimecmp_lo", 32'hFFFF_FFFF, rdata);
        read_reg(clint_addr(soc_map_pkg::MtimecmpHiOffset), rdata);
        check("mtimecmp_hi", 32'hFFFF_FFFF, rdata);
        read_reg(plic_addr(soc_map_pkg::ThresholdOffset), rdata);
        check("threshold", 32'd0, rdata);
        read_reg(plic_addr(soc_map_pkg::ClaimOffset), rdata);
        check("claim", 32'd0, rdata);
        end_test("reset_state", errors_before);
    endtask

    task automatic test_soft_irq();
        int          errors_before;
        logic [31:0] rdata;
        errors_before = errors;
        write_reg(clint_addr(soc_map_pkg::MsipOffset), 32'd1);
        check("ipi_o", 32'd1, ipi_o);
        read_reg(clint_addr(soc_map_pkg::MsipOffset), rdata);
        check("msip", 32'd1, rdata);
        write_reg(clint_addr(soc_map_pkg::MsipOffset), 32'd0);
        check("ipi_o", 32'd0, ipi_o);
        read_reg(clint_addr(soc_map_pkg::MsipOffset), rdata);
        check("msip", 32'd0, rdata);
        end_test("soft_irq", errors_before);
    endtask

    task automatic test_timer();
        int          errors_before;
        int          cycles;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] cmp;
        errors_before = errors;
        read_reg(clint_addr(soc_map_pkg::MtimeLoOffset), lo);
        read_reg(clint_addr(soc_map_pkg::MtimeHiOffset), hi);
        cmp = {hi, lo} + 64'd20;
        write_reg(clint_addr(soc_map_pkg::MtimecmpHiOffset), cmp[63:32]);
        write_reg(clint_addr(soc_map_pkg::MtimecmpLoOffset), cmp[31:0]);
        check("timer_irq_o", 32'd0, timer_irq_o);
        cycles = 0;
        while (!timer_irq_o && cycles < 100) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!timer_irq_o) begin
            $display("timeout: timer_irq_o did not rise within 100 cycles");
            errors++;
        end
        read_reg(clint_addr(soc_map_pkg::MtimeLoOffset), lo);
        read_reg(clint_addr(soc_map_pkg::MtimeHiOffset), hi);
        check("mtime >= mtimecmp", 32'd1, 32'({hi, lo} >= cmp));
        write_reg(clint_addr(soc_map_pkg::MtimecmpHiOffset), 32'hFFFF_FFFF);
        write_reg(clint_addr(soc_map_pkg::MtimecmpLoOffset), 32'hFFFF_FFFF);
        check("timer_irq_o", 32'd0, timer_irq_o);
        end_test("timer", errors_before);
    endtask

    task automatic test_claim_order();
        int          errors_before;
        int          prio [1:irq_pkg::NumSources];
        int          order [$];
        int          best;
        logic [31:0] mask;
        logic [31:0] left;
        logic [31:0] rdata;
        errors_before = errors;
        mask = '0;
        for (int k = 1; k <= irq_pkg::NumSources; k++) begin
            prio[k] = 0;
            if ($urandom % 4 == 0) begin
                mask[k] = 1'b1;
                prio[k] = 1 + int'($urandom % irq_pkg::MaxPriority);
                write_reg(prio_addr(k), prio[k]);
            end
        end
        if (mask == '0) begin
            mask[5] = 1'b1;
            prio[5] = 4;
            write_reg(prio_addr(5), prio[5]);
        end
        write_reg(plic_addr(soc_map_pkg::EnableOffset), mask);
        irq_sources_i = mask[irq_pkg::NumSources:1];
        wait_eip(10);
        // Highest priority first, lowest id wins a tie
        left = mask;
        while (left != '0) begin
            best = 0;
            for (int k = 1; k <= irq_pkg::NumSources; k++) begin
                if (left[k] && (best == 0 || prio[k] > prio[best])) begin
                    best = k;
                end
            end
            order.push_back(best);
            left[best] = 1'b0;
        end
        foreach (order[n]) begin
            read_reg(plic_addr(soc_map_pkg::ClaimOffset), rdata);
            check("claim id", order[n], rdata);
            irq_sources_i[order[n]-1] = 1'b0;
            write_reg(plic_addr(soc_map_pkg::ClaimOffset), order[n]);
        end
        check("eip_o", 32'd0, eip_o);
        read_reg(plic_addr(soc_map_pkg::ClaimOffset), rdata);
        check("claim", 32'd0, rdata);
        write_reg(plic_addr(soc_map_pkg::EnableOffset), 32'd0);
        end_test("claim_order", errors_before);
    endtask

    task automatic test_masking();
        int          errors_before;
        logic [31:0] rdata;
        errors_before = errors;
        write_reg(plic_addr(soc_map_pkg::ThresholdOffset), 32'd3);
        write_reg(prio_addr(9), 32'd5);
        irq_sources_i[8] = 1'b1;
        // Enable bit clear
        hold_eip_low(4);
        read_reg(plic_addr(soc_map_pkg::PendingOffset), rdata);
        check("pending", 32'h0000_0200, rdata);
        read_reg(plic_addr(soc_map_pkg::ClaimOffset), rdata);
        check("claim", 32'd0, rdata);
        // Priority equal to the threshold
        write_reg(prio_addr(9), 32'd3);
        write_reg(plic_addr(soc_map_pkg::EnableOffset), 32'h0000_0200);
        hold_eip_low(4);
        read_reg(plic_addr(soc_map_pkg::ClaimOffset), rdata);
        check("claim", 32'd0, rdata);
        write_reg(prio_addr(9), 32'd4);
        wait_eip(10);
        read_reg(plic_addr(soc_map_pkg::ClaimOffset), rdata);
        check("claim id", 32'd9, rdata);
        irq_sources_i[8] = 1'b0;
        write_reg(plic_addr(soc_map_pkg::ClaimOffset), 32'd9);
        check("eip_o", 32'd0, eip_o);
        write_reg(plic_addr(soc_map_pkg::ThresholdOffset), 32'd0);
        write_reg(plic_addr(soc_map_pkg::EnableOffset), 32'd0);
        end_test("masking", errors_before);
    endtask

    task automatic test_unmapped();
        int          errors_before;
        logic [31:0] rdata;
        logic        err;
        errors_before = errors;
        apb_read(UnmappedCmpAddr, rdata, err);
        check("pslverr_o", 32'd1, err);
        check("prdata_o", 32'd0, rdata);
        apb_write(UnmappedAddr, 32'hFFFF_FFFF, err);
        check("pslverr_o", 32'd1, err);
        read_reg(clint_addr(soc_map_pkg::MsipOffset), rdata);
        check("msip", 32'd0, rdata);
        read_reg(clint_addr(soc_map_pkg::MtimecmpLoOffset), rdata);
        check("mtimecmp_lo", 32'hFFFF_FFFF, rdata);
        read_reg(plic_addr(soc_map_pkg::ThresholdOffset), rdata);
        check("threshold", 32'd0, rdata);
        read_reg(plic_addr(soc_map_pkg::EnableOffset), rdata);
        check("enable", 32'd0, rdata);
        end_test("unmapped", errors_before);
    endtask

    initial begin
        int unused_seed;
        unused_seed   = $urandom(48);
        errors        = 0;
        tests_run     = 0;
        ndmreset_n    = 1'b0;
        psel_i        = 1'b0;
        penable_i     = 1'b0;
        pwrite_i      = 1'b0;
        paddr_i       = '0;
        pwdata_i      = '0;
        irq_sources_i = '0;
        repeat (3) @(negedge clk_i);
        ndmreset_n = 1'b1;
        test_reset_state();
        test_soft_irq();
        test_timer();
        test_claim_order();
        test_masking();
        test_unmapped();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
design/soc_map_pkg.sv
design/irq_pkg.sv
design/periph_apb_ctrl.sv
design/clint_timer.sv
design/plic_core.sv
design/periph_top.sv
test/periph_checker.sv
test/periph_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module periph_tb -f build.f

sim_out=$(./obj_dir/Vperiph_tb 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
echo "run.sh: simulation did not pass"
exit 1
